// ==== verilog/wakeupPkg.sv ====
/*
 * Wakeup scheduler shared definitions
 * Default sizes, the recovery opcode and the selective flush range check
 */
package wakeupPkg;

    localparam int DEFAULT_QUEUE_SIZE  = 8;
    localparam int DEFAULT_ISSUE_WIDTH = 2;
    localparam int DEFAULT_LATENCY     = 3;    // Minimum 1
    localparam int DEFAULT_AL_PTR_BITS = 4;

    typedef enum logic [1:0] {
        RECOVER_NONE  = 2'd0,
        RECOVER_PIPE  = 2'd1,
        RECOVER_RANGE = 2'd2
    } recoveryOp;

    // Pointer inside the circular interval [head, tail) of the active list
    // Equal head and tail means an empty range unless flushAll is set
    function automatic logic inFlushRange(
        input int unsigned head,
        input int unsigned tail,
        input logic        flushAll,
        input int unsigned ptr
    );
        logic inRange;
        if (head <= tail) begin
            inRange = (ptr >= head) && (ptr < tail);
        end else begin
            inRange = (ptr >= head) || (ptr < tail);
        end
        return flushAll || inRange;
    endfunction

endpackage

// ==== verilog/issueSelector.sv ====
/*
 * Issue selector
 * Holds the issue queue entry table and grants ready entries
 * to the issue lanes, lowest index first
 */
`timescale 1ns/1ps

module issueSelector import wakeupPkg::*; #(
    parameter int QUEUE_SIZE  = DEFAULT_QUEUE_SIZE,
    parameter int ISSUE_WIDTH = DEFAULT_ISSUE_WIDTH,
    parameter int AL_PTR_BITS = DEFAULT_AL_PTR_BITS
) (
    input  logic                                             clk,
    input  logic                                             rstN,
    input  logic                                             dispatch,
    input  logic [$clog2(QUEUE_SIZE)-1:0]                    dispatchPtr,
    input  logic [AL_PTR_BITS-1:0]                           dispatchAlPtr,
    input  logic [QUEUE_SIZE-1:0]                            flushIqEntry,
    input  logic                                             stall,
    input  recoveryOp                                        recovery,
    input  logic [QUEUE_SIZE-1:0]                            releaseMask,
    output logic [ISSUE_WIDTH-1:0]                           selValid,
    output logic [ISSUE_WIDTH-1:0][$clog2(QUEUE_SIZE)-1:0]   selPtr,
    output logic [ISSUE_WIDTH-1:0][QUEUE_SIZE-1:0]           selVector,
    output logic [ISSUE_WIDTH-1:0][AL_PTR_BITS-1:0]          selAlPtr
);

    localparam int PTR_BITS = $clog2(QUEUE_SIZE);

    logic [QUEUE_SIZE-1:0]  entryValid;
    logic [QUEUE_SIZE-1:0]  entryIssued;
    logic [AL_PTR_BITS-1:0] entryAlPtr [QUEUE_SIZE];

    // Each lane takes the lowest ready entry not granted to a lower lane
    always_comb begin
        logic [QUEUE_SIZE-1:0] remaining;
        logic                  found;
        remaining = entryValid & ~entryIssued & ~flushIqEntry;
        selValid  = '0;
        selPtr    = '0;
        selVector = '0;
        selAlPtr  = '0;
        for (int l = 0; l < ISSUE_WIDTH; l++) begin
            found = 1'b0;
            for (int e = 0; e < QUEUE_SIZE; e++) begin
                if (!found && remaining[e]) begin
                    found          = 1'b1;
                    remaining[e]   = 1'b0;
                    // Nothing issues while the lanes are frozen
                    selValid[l]    = !stall;
                    selPtr[l]      = PTR_BITS'(e);
                    selVector[l][e] = 1'b1;
                    selAlPtr[l]    = entryAlPtr[e];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            entryValid  <= '0;
            entryIssued <= '0;
        end else if (recovery == RECOVER_PIPE) begin
            entryValid  <= '0;
            entryIssued <= '0;
        end else begin
            // Free entries that leave a lane or get flushed
            for (int e = 0; e < QUEUE_SIZE; e++) begin
                if (releaseMask[e] || flushIqEntry[e]) begin
                    entryValid[e]  <= 1'b0;
                    entryIssued[e] <= 1'b0;
                end
            end
            for (int l = 0; l < ISSUE_WIDTH; l++) begin
                if (selValid[l]) begin
                    entryIssued[selPtr[l]] <= 1'b1;
                end
            end
            if (dispatch) begin
                entryValid[dispatchPtr]  <= 1'b1;
                entryIssued[dispatchPtr] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dispatch) begin
            entryAlPtr[dispatchPtr] <= dispatchAlPtr;
        end
    end

endmodule

// ==== verilog/wakeupLane.sv ====
/*
 * Wakeup lane
 * Carries one issued op through LATENCY pipeline stages, then wakes
 * up its consumers and releases its queue entry
 */
`timescale 1ns/1ps

module wakeupLane import wakeupPkg::*; #(
    parameter int QUEUE_SIZE  = DEFAULT_QUEUE_SIZE,
    parameter int LATENCY     = DEFAULT_LATENCY,
    parameter int AL_PTR_BITS = DEFAULT_AL_PTR_BITS
) (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          stall,
    input  recoveryOp                     recovery,
    input  logic [AL_PTR_BITS-1:0]        flushHead,
    input  logic [AL_PTR_BITS-1:0]        flushTail,
    input  logic                          flushAll,
    input  logic                          selValid,
    input  logic [$clog2(QUEUE_SIZE)-1:0] selPtr,
    input  logic [QUEUE_SIZE-1:0]         selVector,
    input  logic [AL_PTR_BITS-1:0]        selAlPtr,
    output logic                          laneWakeup,
    output logic                          laneRelease,
    output logic [QUEUE_SIZE-1:0]         laneVector,
    output logic                          laneWindow
);

    localparam int COUNT_BITS = $clog2(LATENCY + 1);

    // Stage 0 is the exit stage and ops enter at LATENCY-1
    logic [LATENCY-1:0]                  stageValid;
    logic [LATENCY-1:0][QUEUE_SIZE-1:0]  stageVector;
    logic [LATENCY-1:0][AL_PTR_BITS-1:0] stageAlPtr;

    logic [COUNT_BITS-1:0]  windowCount;
    logic [AL_PTR_BITS-1:0] rangeHead;
    logic [AL_PTR_BITS-1:0] rangeTail;
    logic                   rangeAll;
    logic                   flushHit;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            stageValid <= '0;
        end else if (recovery == RECOVER_PIPE) begin
            stageValid <= '0;
        end else if (!stall) begin
            for (int s = 0; s < LATENCY - 1; s++) begin
                stageValid[s] <= stageValid[s + 1];
            end
            stageValid[LATENCY - 1] <= selValid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            for (int s = 0; s < LATENCY - 1; s++) begin
                stageVector[s] <= stageVector[s + 1];
                stageAlPtr[s]  <= stageAlPtr[s + 1];
            end
            stageVector[LATENCY - 1] <= selVector;
            stageAlPtr[LATENCY - 1]  <= selAlPtr;
        end
    end

    // Flush window covers the ops that may still be in flight
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            windowCount <= '0;
            rangeHead   <= '0;
            rangeTail   <= '0;
            rangeAll    <= 1'b0;
        end else if (recovery == RECOVER_RANGE) begin
            windowCount <= COUNT_BITS'(LATENCY);
            rangeHead   <= flushHead;
            rangeTail   <= flushTail;
            rangeAll    <= flushAll;
        end else if (windowCount != '0 && !stall) begin
            windowCount <= windowCount - 1'b1;
        end
    end

    assign laneWindow = (windowCount != '0);
    assign flushHit   = laneWindow && inFlushRange(32'(rangeHead), 32'(rangeTail),
                                                   rangeAll, 32'(stageAlPtr[0]));

    assign laneWakeup  = stageValid[0] && !flushHit;
    assign laneRelease = stageValid[0] && !stall;

    // One-hot entry of the exiting op
    assign laneVector = stageVector[0];

endmodule

// ==== verilog/wakeupCollector.sv ====
/*
 * Wakeup collector
 * Merges the lane outputs into queue-wide wakeup and release masks
 * and flags a possibly in-flight flushed op
 */
`timescale 1ns/1ps

module wakeupCollector #(
    parameter int QUEUE_SIZE  = 8,
    parameter int ISSUE_WIDTH = 2
) (
    input  logic [ISSUE_WIDTH-1:0]                 laneWakeup,
    input  logic [ISSUE_WIDTH-1:0]                 laneRelease,
    input  logic [ISSUE_WIDTH-1:0][QUEUE_SIZE-1:0] laneVector,
    input  logic [ISSUE_WIDTH-1:0]                 laneWindow,
    output logic [QUEUE_SIZE-1:0]                  wakeupMask,
    output logic [QUEUE_SIZE-1:0]                  releaseMask,
    output logic                                   flushedOpExist
);

    always_comb begin
        wakeupMask  = '0;
        releaseMask = '0;
        for (int l = 0; l < ISSUE_WIDTH; l++) begin
            if (laneWakeup[l]) begin
                wakeupMask = wakeupMask | laneVector[l];
            end
            if (laneRelease[l]) begin
                releaseMask = releaseMask | laneVector[l];
            end
        end
    end

    // Any open window means a flushed op may still sit in a lane
    assign flushedOpExist = |laneWindow;

endmodule

// ==== verilog/wakeupScheduler.sv ====
/*
 * Wakeup scheduler top level
 * Issue selector, ISSUE_WIDTH wakeup lanes and the mask collector
 */
`timescale 1ns/1ps

module wakeupScheduler import wakeupPkg::*; #(
    parameter int QUEUE_SIZE  = DEFAULT_QUEUE_SIZE,
    parameter int ISSUE_WIDTH = DEFAULT_ISSUE_WIDTH,
    parameter int LATENCY     = DEFAULT_LATENCY,
    parameter int AL_PTR_BITS = DEFAULT_AL_PTR_BITS
) (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          dispatch,
    input  logic [$clog2(QUEUE_SIZE)-1:0] dispatchPtr,
    input  logic [AL_PTR_BITS-1:0]        dispatchAlPtr,
    input  logic [QUEUE_SIZE-1:0]         flushIqEntry,
    input  logic                          stall,
    input  recoveryOp                     recovery,
    input  logic [AL_PTR_BITS-1:0]        flushHead,
    input  logic [AL_PTR_BITS-1:0]        flushTail,
    input  logic                          flushAll,
    output logic [QUEUE_SIZE-1:0]         wakeupMask,
    output logic [QUEUE_SIZE-1:0]         releaseMask,
    output logic                          flushedOpExist
);

    localparam int PTR_BITS = $clog2(QUEUE_SIZE);

    logic [ISSUE_WIDTH-1:0]                  selValid;
    logic [ISSUE_WIDTH-1:0][PTR_BITS-1:0]    selPtr;
    logic [ISSUE_WIDTH-1:0][QUEUE_SIZE-1:0]  selVector;
    logic [ISSUE_WIDTH-1:0][AL_PTR_BITS-1:0] selAlPtr;

    logic [ISSUE_WIDTH-1:0]                  laneWakeup;
    logic [ISSUE_WIDTH-1:0]                  laneRelease;
    logic [ISSUE_WIDTH-1:0][QUEUE_SIZE-1:0]  laneVector;
    logic [ISSUE_WIDTH-1:0]                  laneWindow;

    issueSelector #(
        .QUEUE_SIZE  (QUEUE_SIZE),
        .ISSUE_WIDTH (ISSUE_WIDTH),
        .AL_PTR_BITS (AL_PTR_BITS)
    ) i_issueSelector (
        .clk           (clk),
        .rstN          (rstN),
        .dispatch      (dispatch),
        .dispatchPtr   (dispatchPtr),
        .dispatchAlPtr (dispatchAlPtr),
        .flushIqEntry  (flushIqEntry),
        .stall         (stall),
        .recovery      (recovery),
        .releaseMask   (releaseMask),
        .selValid      (selValid),
        .selPtr        (selPtr),
        .selVector     (selVector),
        .selAlPtr      (selAlPtr)
    );

    for (genvar l = 0; l < ISSUE_WIDTH; l++) begin : g_lane
        wakeupLane #(
            .QUEUE_SIZE  (QUEUE_SIZE),
            .LATENCY     (LATENCY),
            .AL_PTR_BITS (AL_PTR_BITS)
        ) i_wakeupLane (
            .clk         (clk),
            .rstN        (rstN),
            .stall       (stall),
            .recovery    (recovery),
            .flushHead   (flushHead),
            .flushTail   (flushTail),
            .flushAll    (flushAll),
            .selValid    (selValid[l]),
            .selPtr      (selPtr[l]),
            .selVector   (selVector[l]),
            .selAlPtr    (selAlPtr[l]),
            .laneWakeup  (laneWakeup[l]),
            .laneRelease (laneRelease[l]),
            .laneVector  (laneVector[l]),
            .laneWindow  (laneWindow[l])
        );
    end

    wakeupCollector #(
        .QUEUE_SIZE  (QUEUE_SIZE),
        .ISSUE_WIDTH (ISSUE_WIDTH)
    ) i_wakeupCollector (
        .laneWakeup     (laneWakeup),
        .laneRelease    (laneRelease),
        .laneVector     (laneVector),
        .laneWindow     (laneWindow),
        .wakeupMask     (wakeupMask),
        .releaseMask    (releaseMask),
        .flushedOpExist (flushedOpExist)
    );

endmodule

// ==== tb/wakeupScheduler_sva.sv ====
/*
 * Wakeup scheduler assertions
 * Release back-pressure, wakeup inside release and the flush window flag
 */
`timescale 1ns/1ps

module wakeupSchedulerSva import wakeupPkg::*; #(
    parameter int QUEUE_SIZE = DEFAULT_QUEUE_SIZE
) (
    input logic                  clk,
    input logic                  rstN,
    input logic                  stall,
    input recoveryOp             recovery,
    input logic [QUEUE_SIZE-1:0] wakeupMask,
    input logic [QUEUE_SIZE-1:0] releaseMask,
    input logic                  flushedOpExist
);

    // Stalled lanes keep their exiting ops
    noReleaseOnStall: assert property (@(posedge clk) disable iff (!rstN)
        stall |-> (releaseMask == '0))
        else $error("releaseMask %h while stalled", releaseMask);

    // An op that wakes up also leaves its lane
    wakeupInRelease: assert property (@(posedge clk) disable iff (!rstN)
        !stall |-> ((wakeupMask & ~releaseMask) == '0))
        else $error("wakeupMask %h outside releaseMask %h", wakeupMask, releaseMask);

    windowAfterRange: assert property (@(posedge clk) disable iff (!rstN)
        (recovery == RECOVER_RANGE) |=> flushedOpExist)
        else $error("flushedOpExist low after a range recovery");

endmodule

// ==== tb/wakeupSchedulerTb.sv ====
/*
 * Wakeup scheduler testbench
 * Applies a per-cycle stimulus table and compares the masks and the
 * flush flag with values from a cycle-level model of queue, lanes and window
 */
`timescale 1ns/1ps

module wakeupSchedulerTb import wakeupPkg::*; ();

    localparam int QUEUE_SIZE   = DEFAULT_QUEUE_SIZE;
    localparam int ISSUE_WIDTH  = DEFAULT_ISSUE_WIDTH;
    localparam int LATENCY      = DEFAULT_LATENCY;
    localparam int AL_PTR_BITS  = DEFAULT_AL_PTR_BITS;
    localparam int PTR_BITS     = $clog2(QUEUE_SIZE);
    localparam int RESET_CYCLES = 5;

    typedef struct packed {
        logic                   dispatch;
        logic [PTR_BITS-1:0]    ptr;
        logic [AL_PTR_BITS-1:0] alPtr;
        logic                   stall;
        recoveryOp              recovery;
        logic [AL_PTR_BITS-1:0] head;
        logic [AL_PTR_BITS-1:0] tail;
        logic                   flushAll;
        logic [QUEUE_SIZE-1:0]  flushIq;
        logic [QUEUE_SIZE-1:0]  expWakeup;
        logic [QUEUE_SIZE-1:0]  expRelease;
        logic                   expFlushed;
    } stepRow;

    logic                   clk;
    logic                   rstN;
    logic                   dispatch;
    logic [PTR_BITS-1:0]    dispatchPtr;
    logic [AL_PTR_BITS-1:0] dispatchAlPtr;
    logic [QUEUE_SIZE-1:0]  flushIqEntry;
    logic                   stall;
    recoveryOp              recovery;
    logic [AL_PTR_BITS-1:0] flushHead;
    logic [AL_PTR_BITS-1:0] flushTail;
    logic                   flushAll;
    logic [QUEUE_SIZE-1:0]  wakeupMask;
    logic [QUEUE_SIZE-1:0]  releaseMask;
    logic                   flushedOpExist;

    stepRow steps[$];
    int     errorCount = 0;
    int     checkCount = 0;
    int     cycleCount = 0;
    int     limitCycles = 0;

    wakeupScheduler #(
        .QUEUE_SIZE  (QUEUE_SIZE),
        .ISSUE_WIDTH (ISSUE_WIDTH),
        .LATENCY     (LATENCY),
        .AL_PTR_BITS (AL_PTR_BITS)
    ) i_dut (
        .clk            (clk),
        .rstN           (rstN),
        .dispatch       (dispatch),
        .dispatchPtr    (dispatchPtr),
        .dispatchAlPtr  (dispatchAlPtr),
        .flushIqEntry   (flushIqEntry),
        .stall          (stall),
        .recovery       (recovery),
        .flushHead      (flushHead),
        .flushTail      (flushTail),
        .flushAll       (flushAll),
        .wakeupMask     (wakeupMask),
        .releaseMask    (releaseMask),
        .flushedOpExist (flushedOpExist)
    );

    bind wakeupScheduler wakeupSchedulerSva #(
        .QUEUE_SIZE (QUEUE_SIZE)
    ) i_sva (
        .clk            (clk),
        .rstN           (rstN),
        .stall          (stall),
        .recovery       (recovery),
        .wakeupMask     (wakeupMask),
        .releaseMask    (releaseMask),
        .flushedOpExist (flushedOpExist)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Circular interval [head, tail) of the active list
    // Equal head and tail gives an empty range
    function automatic logic alPtrFlushed(input int head, input int tail, input logic all,
                                          input int ptr);
        if (all) begin
            return 1'b1;
        end
        if (head <= tail) begin
            return (ptr >= head) && (ptr < tail);
        end
        return (ptr >= head) || (ptr < tail);
    endfunction

    task automatic addStep(input logic disp, input int ptr, input int al, input logic stl,
                           input recoveryOp rec, input int head, input int tail,
                           input logic all, input logic [QUEUE_SIZE-1:0] fiq);
        stepRow row;
        row          = '0;
        row.dispatch = disp;
        row.ptr      = PTR_BITS'(ptr);
        row.alPtr    = AL_PTR_BITS'(al);
        row.stall    = stl;
        row.recovery = rec;
        row.head     = AL_PTR_BITS'(head);
        row.tail     = AL_PTR_BITS'(tail);
        row.flushAll = all;
        row.flushIq  = fiq;
        steps.push_back(row);
    endtask

    task automatic idleSteps(input int n, input logic stl);
        repeat (n) addStep(1'b0, 0, 0, stl, RECOVER_NONE, 0, 0, 1'b0, '0);
    endtask

    task automatic dispatchStep(input int ptr, input int al, input logic stl);
        addStep(1'b1, ptr, al, stl, RECOVER_NONE, 0, 0, 1'b0, '0);
    endtask

    task automatic recoverStep(input recoveryOp rec, input int head, input int tail,
                               input logic all);
        addStep(1'b0, 0, 0, 1'b0, rec, head, tail, all, '0);
    endtask

    task automatic buildTable();
        // Single op then reuse of the freed entry
        dispatchStep(0, 1, 1'b0);
        idleSteps(5, 1'b0);
        dispatchStep(0, 2, 1'b0);
        idleSteps(5, 1'b0);
        // Four ops become ready together behind a stall
        dispatchStep(1, 3, 1'b1);
        dispatchStep(2, 4, 1'b1);
        dispatchStep(3, 5, 1'b1);
        dispatchStep(4, 6, 1'b1);
        idleSteps(6, 1'b0);
        // Stalls with the op in the middle stage and then in the exit stage
        dispatchStep(5, 7, 1'b0);
        idleSteps(2, 1'b0);
        idleSteps(2, 1'b1);
        idleSteps(1, 1'b0);
        idleSteps(2, 1'b1);
        idleSteps(5, 1'b0);
        // Wrapping range 14..1 holds alPtr 15 but not 3
        dispatchStep(0, 15, 1'b1);
        dispatchStep(1, 3, 1'b1);
        idleSteps(2, 1'b0);
        recoverStep(RECOVER_RANGE, 14, 2, 1'b0);
        idleSteps(5, 1'b0);
        // flushAll window stretched by one stall cycle
        dispatchStep(2, 9, 1'b0);
        recoverStep(RECOVER_RANGE, 0, 0, 1'b1);
        idleSteps(1, 1'b0);
        idleSteps(1, 1'b1);
        idleSteps(5, 1'b0);
        // Pipe recovery with two ops in flight and one just issued
        dispatchStep(3, 1, 1'b1);
        dispatchStep(4, 2, 1'b1);
        dispatchStep(6, 3, 1'b1);
        idleSteps(2, 1'b0);
        recoverStep(RECOVER_PIPE, 0, 0, 1'b0);
        idleSteps(5, 1'b0);
        // Entry 7 invalidated before it can be selected
        dispatchStep(7, 4, 1'b0);
        addStep(1'b0, 0, 0, 1'b0, RECOVER_NONE, 0, 0, 1'b0, QUEUE_SIZE'(1) << 7);
        dispatchStep(0, 5, 1'b0);
        idleSteps(5, 1'b0);
    endtask

    // Walks the table once and fills the expected columns
    task automatic runModel();
        logic [QUEUE_SIZE-1:0] valid;
        logic [QUEUE_SIZE-1:0] issued;
        logic [QUEUE_SIZE-1:0] ready;
        logic [LATENCY-1:0]    stgValid [ISSUE_WIDTH];
        int                    stgPtr [ISSUE_WIDTH][LATENCY];
        int                    stgAl [ISSUE_WIDTH][LATENCY];
        int                    entryAl [QUEUE_SIZE];
        int                    selPtr [ISSUE_WIDTH];
        logic                  selValid [ISSUE_WIDTH];
        int                    window;
        int                    rHead;
        int                    rTail;
        logic                  rAll;
        stepRow                row;
        valid  = '0;
        issued = '0;
        window = 0;
        rHead  = 0;
        rTail  = 0;
        rAll   = 1'b0;
        foreach (entryAl[e]) entryAl[e] = 0;
        foreach (stgValid[l]) stgValid[l] = '0;
        foreach (stgPtr[l, s]) begin
            stgPtr[l][s] = 0;
            stgAl[l][s]  = 0;
        end
        for (int i = 0; i < steps.size(); i++) begin
            row   = steps[i];
            ready = valid & ~issued & ~row.flushIq;
            for (int l = 0; l < ISSUE_WIDTH; l++) begin
                selPtr[l] = -1;
                for (int e = 0; e < QUEUE_SIZE; e++) begin
                    if (selPtr[l] < 0 && ready[e]) begin
                        selPtr[l] = e;
                        ready[e]  = 1'b0;
                    end
                end
                selValid[l] = (selPtr[l] >= 0) && !row.stall;
            end
            row.expWakeup  = '0;
            row.expRelease = '0;
            row.expFlushed = (window != 0);
            for (int l = 0; l < ISSUE_WIDTH; l++) begin
                if (stgValid[l][0]) begin
                    if (!(window != 0 && alPtrFlushed(rHead, rTail, rAll, stgAl[l][0]))) begin
                        row.expWakeup[stgPtr[l][0]] = 1'b1;
                    end
                    if (!row.stall) begin
                        row.expRelease[stgPtr[l][0]] = 1'b1;
                    end
                end
            end
            steps[i] = row;
            // State update at the edge that ends this cycle
            if (row.recovery == RECOVER_PIPE) begin
                valid  = '0;
                issued = '0;
                foreach (stgValid[l]) stgValid[l] = '0;
            end else begin
                if (!row.stall) begin
                    for (int l = 0; l < ISSUE_WIDTH; l++) begin
                        for (int s = 0; s < LATENCY - 1; s++) begin
                            stgValid[l][s] = stgValid[l][s + 1];
                            stgPtr[l][s]   = stgPtr[l][s + 1];
                            stgAl[l][s]    = stgAl[l][s + 1];
                        end
                        stgValid[l][LATENCY - 1] = selValid[l];
                        stgPtr[l][LATENCY - 1]   = selValid[l] ? selPtr[l] : 0;
                        stgAl[l][LATENCY - 1]    = selValid[l] ? entryAl[selPtr[l]] : 0;
                    end
                end
                valid  = valid & ~(row.expRelease | row.flushIq);
                issued = issued & ~(row.expRelease | row.flushIq);
                for (int l = 0; l < ISSUE_WIDTH; l++) begin
                    if (selValid[l]) begin
                        issued[selPtr[l]] = 1'b1;
                    end
                end
                if (row.dispatch) begin
                    valid[row.ptr]   = 1'b1;
                    issued[row.ptr]  = 1'b0;
                    entryAl[row.ptr] = int'(row.alPtr);
                end
            end
            if (row.recovery == RECOVER_RANGE) begin
                window = LATENCY;
                rHead  = int'(row.head);
                rTail  = int'(row.tail);
                rAll   = row.flushAll;
            end else if (window != 0 && !row.stall) begin
                window--;
            end
        end
    endtask

    task automatic compareValue(input string name, input int step,
                                input logic [QUEUE_SIZE-1:0] got,
                                input logic [QUEUE_SIZE-1:0] exp);
        checkCount++;
        assert (got === exp) else begin
            errorCount++;
            $display("Fail %0t: step %0d %s is %h, expected %h", $time, step, name, got, exp);
        end
    endtask

    initial begin
        rstN          = 1'b0;
        dispatch      = 1'b0;
        dispatchPtr   = '0;
        dispatchAlPtr = '0;
        flushIqEntry  = '0;
        stall         = 1'b0;
        recovery      = RECOVER_NONE;
        flushHead     = '0;
        flushTail     = '0;
        flushAll      = 1'b0;
        buildTable();
        runModel();
        limitCycles = RESET_CYCLES + steps.size() + LATENCY + 20;
        repeat (RESET_CYCLES) @(negedge clk);
        rstN = 1'b1;
        for (int i = 0; i < steps.size(); i++) begin
            dispatch      = steps[i].dispatch;
            dispatchPtr   = steps[i].ptr;
            dispatchAlPtr = steps[i].alPtr;
            flushIqEntry  = steps[i].flushIq;
            stall         = steps[i].stall;
            recovery      = steps[i].recovery;
            flushHead     = steps[i].head;
            flushTail     = steps[i].tail;
            flushAll      = steps[i].flushAll;
            #1;
            compareValue("wakeupMask", i, wakeupMask, steps[i].expWakeup);
            compareValue("releaseMask", i, releaseMask, steps[i].expRelease);
            compareValue("flushedOpExist", i, QUEUE_SIZE'(flushedOpExist),
                         QUEUE_SIZE'(steps[i].expFlushed));
            @(negedge clk);
        end
        $display("Summary: %0d steps, %0d checks, %0d errors",
                 steps.size(), checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // Ends a run that overruns the table length
    initial begin
        wait (limitCycles != 0);
        while (cycleCount < limitCycles) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout after %0d cycles, the stimulus table did not complete", cycleCount);
        $display("Testbench failed");
        $finish;
    end

endmodule

// ==== wakeupScheduler.f ====
verilog/wakeupPkg.sv
verilog/issueSelector.sv
verilog/wakeupLane.sv
verilog/wakeupCollector.sv
verilog/wakeupScheduler.sv
tb/wakeupScheduler_sva.sv
tb/wakeupSchedulerTb.sv

// ==== runSim.sh ====
#!/bin/sh
# Builds the wakeup scheduler testbench with Verilator and runs it.
# Exits non-zero unless the log holds the pass message.

LOG=sim.log

verilator --binary --assert -Wno-fatal \
    --top-module wakeupSchedulerTb \
    -f wakeupScheduler.f \
    -o wakeupSchedulerSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/wakeupSchedulerSim +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Testbench passed" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
